// ==== src/mini_core_pkg.sv ====
package mini_core_pkg;

	// --------------------
	// Widths
	// --------------------

	typedef logic [31:0] word_t;    // Instruction or data word
	typedef logic [31:0] addr_t;    // Byte address, PC width
	typedef logic [4:0]  reg_idx_t; // Architectural register index
	typedef logic [6:0]  opcode_t;  // inst[6:0]

	// --------------------
	// Opcodes, RV32I subset
	// --------------------

	// Register-register ALU group, ADD and SUB
	localparam opcode_t OPC_OP     = 7'b0110011;

	// Register-immediate ALU group, ADDI only
	localparam opcode_t OPC_OP_IMM = 7'b0010011;

	// Conditional branches, BEQ and BNE
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	// Jump and link
	localparam opcode_t OPC_JAL    = 7'b1101111;

	// --------------------
	// Reset state
	// --------------------

	// First fetch after reset
	localparam addr_t RESET_PC = 32'h0000_0000;

	// Notes on encodings used by decode and execute
	//   funct3 lives in inst[14:12] for all three groups above
	//   inst[30] picks SUB over ADD in the OP group
	//   Anything outside the subset still flows down the pipe
	//   and retires as a bubble with no register write

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
	parameter mini_core_pkg::addr_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 except,
	input  logic                 redirect,
	input  mini_core_pkg::addr_t redirect_target,
	output mini_core_pkg::addr_t rom_addr,
	input  mini_core_pkg::word_t rom_data,
	output logic                 if_valid,
	output mini_core_pkg::addr_t if_pc,
	output mini_core_pkg::word_t if_inst
);
	import mini_core_pkg::*;

	addr_t pc;       // Address being fetched this cycle
	addr_t pc_plus4; // Sequential successor
	addr_t next_pc;  // Chosen PC for the coming edge
	logic  flush;    // Kill whatever is in IF right now

	// --------------------
	// Next PC selection
	// --------------------

	assign pc_plus4 = pc + 32'd4;
	assign flush    = except | redirect;

	// Exception beats a branch or jump resolved in the same cycle
	always_comb
	begin
		if (except)
			next_pc = EXC_VECTOR;
		else if (redirect)
			next_pc = redirect_target;     // Taken branch or JAL from EX
		else
			next_pc = pc_plus4;
	end

	// PC moves every clock with no stalls
	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= next_pc;
	end

	// ROM read is combinational so the PC goes straight out
	assign rom_addr = pc;

	// --------------------
	// IF/ID register
	// --------------------

	// Valid bit cleared by reset and by any flush
	always_ff @(posedge clk)
	begin
		if (reset)
			if_valid <= 1'b0;
		else
			if_valid <= ~flush;   // Word fetched this cycle is wrong path on flush
	end

	// Fetched word and its PC
	always_ff @(posedge clk)
	begin
		if_pc   <= pc;
		if_inst <= rom_data;
	end

endmodule

// ==== src/inst_rom.sv ====
`timescale 1ns/1ns

module inst_rom #(
	parameter int ROM_WORDS = 64
) (
	input  logic                 clk,
	input  logic                 we,
	input  mini_core_pkg::addr_t waddr,
	input  mini_core_pkg::word_t wdata,
	input  mini_core_pkg::addr_t addr,
	output mini_core_pkg::word_t data
);
	import mini_core_pkg::*;

	localparam int IDX_W = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;

	word_t             mem [ROM_WORDS]; // Program storage
	logic [IDX_W-1:0]  rd_idx;          // Word index of the fetch address
	logic [IDX_W-1:0]  wr_idx;          // Word index of the load address

	// Byte address to word index, wrapping at the ROM size
	assign rd_idx = IDX_W'((addr >> 2) % ROM_WORDS);
	assign wr_idx = IDX_W'((waddr >> 2) % ROM_WORDS);

	// Load port, one word per clock
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_idx] <= wdata;
	end

	assign data = mem[rd_idx];  // Asynchronous read for fetch

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  mini_core_pkg::reg_idx_t rs1,
	input  mini_core_pkg::reg_idx_t rs2,
	output mini_core_pkg::word_t    rs1_data,
	output mini_core_pkg::word_t    rs2_data,
	input  logic                    we,
	input  mini_core_pkg::reg_idx_t rd,
	input  mini_core_pkg::word_t    wdata
);
	import mini_core_pkg::*;

	word_t regs [32];   // x0 slot stays zero, never written
	logic  wr_ok;       // Write enabled and not aimed at x0

	assign wr_ok = we && (rd != '0);

	// Whole file cleared on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_ok)
			regs[rd] <= wdata;
	end

	// Read ports
	// Bypass covers EX writing the register ID reads in the same cycle
	assign rs1_data = (rs1 == '0)               ? '0    :
	                  (wr_ok && (rd == rs1))    ? wdata : regs[rs1];
	assign rs2_data = (rs2 == '0)               ? '0    :
	                  (wr_ok && (rd == rs2))    ? wdata : regs[rs2];

endmodule

// ==== src/decode_unit.sv ====
`timescale 1ns/1ns

module decode_unit (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    if_valid,
	input  mini_core_pkg::addr_t    if_pc,
	input  mini_core_pkg::word_t    if_inst,
	output mini_core_pkg::reg_idx_t rs1,
	output mini_core_pkg::reg_idx_t rs2,
	input  mini_core_pkg::word_t    rs1_data,
	input  mini_core_pkg::word_t    rs2_data,
	output logic                    id_valid,
	output mini_core_pkg::addr_t    id_pc,
	output mini_core_pkg::opcode_t  id_opcode,
	output logic [2:0]              id_funct3,
	output logic                    id_sub,
	output mini_core_pkg::reg_idx_t id_rd,
	output mini_core_pkg::word_t    id_rs1_val,
	output mini_core_pkg::word_t    id_rs2_val,
	output mini_core_pkg::word_t    id_imm
);
	import mini_core_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	reg_idx_t   rd;
	logic       sub;
	word_t      imm_i;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm;

	// --------------------
	// Field split
	// --------------------

	assign opcode = if_inst[6:0];
	assign rd     = if_inst[11:7];
	assign funct3 = if_inst[14:12];
	assign rs1    = if_inst[19:15];   // To register file
	assign rs2    = if_inst[24:20];

	// inst[30] is immediate data for ADDI, only meaningful in OP
	assign sub = (opcode == OPC_OP) && if_inst[30];

	// --------------------
	// Immediates
	// --------------------

	assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
	assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
	                if_inst[30:25], if_inst[11:8], 1'b0};
	assign imm_j = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12],
	                if_inst[20], if_inst[30:21], 1'b0};

	// Format picked by opcode
	always_comb
	begin
		case (opcode)
			OPC_OP_IMM: imm = imm_i;
			OPC_BRANCH: imm = imm_b;
			OPC_JAL:    imm = imm_j;
			default:    imm = '0;   // OP and unknown words need none
		endcase
	end

	// --------------------
	// ID/EX register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (reset)
			id_valid <= 1'b0;
		else if (flush)
			id_valid <= 1'b0;     // Younger than a redirect or exception
		else
			id_valid <= if_valid;
	end

	// Payload travels unqualified, id_valid gates its use
	always_ff @(posedge clk)
	begin
		id_pc      <= if_pc;
		id_opcode  <= opcode;
		id_funct3  <= funct3;
		id_sub     <= sub;
		id_rd      <= rd;
		id_rs1_val <= rs1_data;   // Already bypassed by the register file
		id_rs2_val <= rs2_data;
		id_imm     <= imm;
	end

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit (
	input  logic                    id_valid,
	input  mini_core_pkg::addr_t    id_pc,
	input  mini_core_pkg::opcode_t  id_opcode,
	input  logic [2:0]              id_funct3,
	input  logic                    id_sub,
	input  mini_core_pkg::reg_idx_t id_rd,
	input  mini_core_pkg::word_t    id_rs1_val,
	input  mini_core_pkg::word_t    id_rs2_val,
	input  mini_core_pkg::word_t    id_imm,
	output logic                    redirect,
	output mini_core_pkg::addr_t    redirect_target,
	output logic                    retire_valid,
	output mini_core_pkg::addr_t    retire_pc,
	output logic                    wb_en,
	output mini_core_pkg::reg_idx_t wb_rd,
	output mini_core_pkg::word_t    wb_data
);
	import mini_core_pkg::*;

	localparam logic [2:0] F3_ADD = 3'b000;   // ADD, SUB, ADDI
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	logic  is_alu;     // ADD, SUB or ADDI
	logic  is_jal;
	logic  is_branch;  // BEQ or BNE, other funct3 ignored
	logic  rs_equal;
	logic  br_taken;
	word_t operand_b;
	word_t alu_out;
	addr_t link_pc;

	// --------------------
	// Instruction class
	// --------------------

	assign is_alu    = ((id_opcode == OPC_OP) || (id_opcode == OPC_OP_IMM))
	                   && (id_funct3 == F3_ADD);
	assign is_jal    = (id_opcode == OPC_JAL);
	assign is_branch = (id_opcode == OPC_BRANCH)
	                   && ((id_funct3 == F3_BEQ) || (id_funct3 == F3_BNE));

	// --------------------
	// ALU
	// --------------------

	// Second operand is rs2 for OP, the immediate for OP_IMM
	assign operand_b = (id_opcode == OPC_OP) ? id_rs2_val : id_imm;
	assign alu_out   = id_sub ? (id_rs1_val - operand_b)
	                          : (id_rs1_val + operand_b);

	// --------------------
	// Branch and jump
	// --------------------

	assign rs_equal = (id_rs1_val == id_rs2_val);
	assign br_taken = is_branch &&
	                  (((id_funct3 == F3_BEQ) &&  rs_equal) ||
	                   ((id_funct3 == F3_BNE) && !rs_equal));

	assign link_pc = id_pc + 32'd4;   // JAL return address

	// One-cycle pulse, since the flush kills the next candidate
	assign redirect        = id_valid && (br_taken || is_jal);
	assign redirect_target = id_pc + id_imm;   // B and J share pc relative form

	// --------------------
	// Write-back and retire
	// --------------------

	assign retire_valid = id_valid;   // Bubbles and unknown words still retire
	assign retire_pc    = id_pc;

	// x0 writes never leave this unit
	assign wb_en   = id_valid && (is_alu || is_jal) && (id_rd != '0);
	assign wb_rd   = id_rd;
	assign wb_data = is_jal ? link_pc : alu_out;

endmodule

// ==== src/mini_core.sv ====
`timescale 1ns/1ns

module mini_core #(
	parameter int                   ROM_WORDS  = 64,
	parameter mini_core_pkg::addr_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    except,
	input  logic                    prog_we,
	input  mini_core_pkg::addr_t    prog_addr,
	input  mini_core_pkg::word_t    prog_data,
	output logic                    retire_valid,
	output mini_core_pkg::addr_t    retire_pc,
	output logic                    wb_en,
	output mini_core_pkg::reg_idx_t wb_rd,
	output mini_core_pkg::word_t    wb_data
);
	import mini_core_pkg::*;

	// --------------------
	// Stage wiring
	// --------------------

	addr_t    rom_addr;
	word_t    rom_data;
	logic     if_valid;
	addr_t    if_pc;
	word_t    if_inst;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rs1_data;
	word_t    rs2_data;
	logic     id_valid;
	addr_t    id_pc;
	opcode_t  id_opcode;
	logic [2:0] id_funct3;
	logic     id_sub;
	reg_idx_t id_rd;
	word_t    id_rs1_val;
	word_t    id_rs2_val;
	word_t    id_imm;
	logic     redirect;
	addr_t    redirect_target;
	logic     id_flush;   // Either event squashes ID

	assign id_flush = except | redirect;

	fetch_unit #(.EXC_VECTOR(EXC_VECTOR)) i_fetch_unit (
		.clk(clk), .reset(reset), .except(except), .redirect(redirect),
		.redirect_target(redirect_target), .rom_addr(rom_addr), .rom_data(rom_data),
		.if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst)
	);

	inst_rom #(.ROM_WORDS(ROM_WORDS)) i_inst_rom (
		.clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
		.addr(rom_addr), .data(rom_data)
	);

	decode_unit i_decode_unit (
		.clk(clk), .reset(reset), .flush(id_flush),
		.if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.id_valid(id_valid), .id_pc(id_pc), .id_opcode(id_opcode),
		.id_funct3(id_funct3), .id_sub(id_sub), .id_rd(id_rd),
		.id_rs1_val(id_rs1_val), .id_rs2_val(id_rs2_val), .id_imm(id_imm)
	);

	// Write port fed straight from EX
	reg_file i_reg_file (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(wb_en), .rd(wb_rd), .wdata(wb_data)
	);

	execute_unit i_execute_unit (
		.id_valid(id_valid), .id_pc(id_pc), .id_opcode(id_opcode),
		.id_funct3(id_funct3), .id_sub(id_sub), .id_rd(id_rd),
		.id_rs1_val(id_rs1_val), .id_rs2_val(id_rs2_val), .id_imm(id_imm),
		.redirect(redirect), .redirect_target(redirect_target),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

// ==== verif/mini_core_model.svh ====
// --------------------
// Program image
// --------------------

typedef enum {K_ADD, K_SUB, K_ADDI, K_BEQ, K_BNE, K_JAL, K_NOP} kind_e;

kind_e    p_kind [ROM_WORDS];
reg_idx_t p_rd   [ROM_WORDS];
reg_idx_t p_rs1  [ROM_WORDS];
reg_idx_t p_rs2  [ROM_WORDS];
word_t    p_imm  [ROM_WORDS];   // ADDI value or pc relative byte offset
word_t    p_word [ROM_WORDS];   // Encoded word for the load port

word_t    m_regs [32];          // Architectural registers
addr_t    m_pc;                 // PC expected at the next retire

// Random program, registers x0..x7 only so results feed each other
task automatic gen_program();
	word_t r;
	int    t;
	for (int i = 0; i < ROM_WORDS; i++)
	begin
		r         = $urandom();
		t         = (i + $urandom_range(1, ROM_WORDS - 1)) % ROM_WORDS;   // Never itself
		p_kind[i] = kind_e'($urandom_range(0, 6));
		p_rd[i]   = reg_idx_t'($urandom_range(0, 7));
		p_rs1[i]  = reg_idx_t'($urandom_range(0, 7));
		p_rs2[i]  = reg_idx_t'($urandom_range(0, 7));
		if (p_kind[i] == K_ADDI)
			p_imm[i] = {{20{r[11]}}, r[11:0]};
		else
			p_imm[i] = word_t'((t - i) * 4);   // Target stays inside the ROM
		case (p_kind[i])
			K_ADD:  p_word[i] = {7'b0000000, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], OPC_OP};
			K_SUB:  p_word[i] = {7'b0100000, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], OPC_OP};
			K_ADDI: p_word[i] = {p_imm[i][11:0], p_rs1[i], 3'b000, p_rd[i], OPC_OP_IMM};
			K_BEQ,
			K_BNE:  p_word[i] = {p_imm[i][12], p_imm[i][10:5], p_rs2[i], p_rs1[i],
			                     (p_kind[i] == K_BNE) ? 3'b001 : 3'b000,
			                     p_imm[i][4:1], p_imm[i][11], OPC_BRANCH};
			K_JAL:  p_word[i] = {p_imm[i][20], p_imm[i][10:1], p_imm[i][11],
			                     p_imm[i][19:12], p_rd[i], OPC_JAL};
			// LUI or XOR, both outside the subset
			default: p_word[i] = r[31] ? {r[24:0], 7'b0110111}
			                           : {r[11:0], p_rs1[i], 3'b100, p_rd[i], OPC_OP};
		endcase
	end
endtask

task automatic clear_model();
	for (int k = 0; k < 32; k++)
		m_regs[k] = '0;   // x0 is never written afterwards
	m_pc = RESET_PC;
endtask

// Retire the instruction at m_pc and give its expected write-back
task automatic step_model(output logic en, output reg_idx_t rd, output word_t data);
	int    idx;
	word_t a;
	word_t b;
	logic  taken;
	idx   = int'((m_pc >> 2) % ROM_WORDS);   // Fetch wraps at the ROM size
	a     = m_regs[p_rs1[idx]];
	b     = m_regs[p_rs2[idx]];
	rd    = p_rd[idx];
	data  = (p_kind[idx] == K_SUB)  ? a - b :
	        (p_kind[idx] == K_ADDI) ? a + p_imm[idx] :
	        (p_kind[idx] == K_JAL)  ? m_pc + 32'd4 : a + b;
	en    = (p_kind[idx] != K_BEQ) && (p_kind[idx] != K_BNE) && (p_kind[idx] != K_NOP)
	        && (rd != '0);   // No write to x0
	taken = (p_kind[idx] == K_JAL) || ((p_kind[idx] == K_BEQ) && (a == b))
	        || ((p_kind[idx] == K_BNE) && (a != b));
	if (en)
		m_regs[rd] = data;
	m_pc  = taken ? m_pc + p_imm[idx] : m_pc + 32'd4;
endtask

// ==== verif/mini_core_tb.sv ====
`timescale 1ns/1ns

module mini_core_tb;
	import mini_core_pkg::*;

	localparam int    ROM_WORDS  = 64;
	localparam addr_t EXC_VECTOR = 32'h0000_0080;
	localparam int    RUN_CYCLES = 2000;
	localparam int    MAX_GAP    = 4;   // Cycles allowed with nothing retiring

	logic     clk;
	logic     reset;
	logic     except;
	logic     prog_we;
	addr_t    prog_addr;
	word_t    prog_data;
	logic     retire_valid;
	addr_t    retire_pc;
	logic     wb_en;
	reg_idx_t wb_rd;
	word_t    wb_data;

	`include "mini_core_model.svh"

	mini_core #(
		.ROM_WORDS(ROM_WORDS),
		.EXC_VECTOR(EXC_VECTOR)
	) i_mini_core (
		.clk(clk), .reset(reset), .except(except),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	always #5 clk = ~clk;   // 10 ns period

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
		                   $time, name, got, exp));
	endtask

	// Compare the retiring instruction with the model and step it
	task automatic check_retire();
		addr_t    e_pc;
		logic     e_en;
		reg_idx_t e_rd;
		word_t    e_data;
		e_pc = m_pc;
		step_model(e_en, e_rd, e_data);
		assert (retire_pc === e_pc)
		else report_mismatch("retire_pc", retire_pc, e_pc);
		assert (wb_en === e_en)
		else report_mismatch("wb_en", wb_en, e_en);
		if (e_en)   // rd and data only mean something on a write
		begin
			assert (wb_rd === e_rd)
			else report_mismatch("wb_rd", wb_rd, e_rd);
			assert (wb_data === e_data)
			else report_mismatch("wb_data", wb_data, e_data);
		end
	endtask

	initial
	begin
		int seed_draw;
		int waited;
		int gap;
		int exc_wait;
		seed_draw = $urandom(25363);   // Seeds the whole run
		clk       = 1'b0;
		reset     = 1'b1;
		except    = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		gen_program();

		// ROM load one word per edge while reset holds
		for (int i = 0; i < ROM_WORDS; i++)
		begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= addr_t'(i * 4);
			prog_data <= p_word[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		clear_model();

		// PC 0 retires on the third cycle after reset falls
		waited = 0;
		while ((retire_valid !== 1'b1) && (waited < 10))
		begin
			assert (wb_en === 1'b0)   // No write while the pipe is empty
			else report_mismatch("wb_en", wb_en, 1'b0);
			@(posedge clk);
			waited++;
		end
		assert (retire_valid === 1'b1)
		else fail_run("timeout waiting for the first instruction to retire");
		assert (waited == 3)
		else fail_run("first instruction retired on the wrong cycle after reset");

		// --------------------
		// Main run
		// --------------------

		gap      = 0;
		exc_wait = $urandom_range(6, 30);
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
		begin
			if (retire_valid === 1'b1)
			begin
				check_retire();
				gap = 0;
			end
			else
			begin
				gap++;
				assert (gap <= MAX_GAP)
				else fail_run("no instruction retired for more than 4 cycles");
				assert (wb_en === 1'b0)   // Bubbles write nothing
				else report_mismatch("wb_en", wb_en, 1'b0);
			end
			if (except)
				m_pc = EXC_VECTOR;   // Younger work flushed and the vector retires next

			// One-cycle except pulses spaced far enough apart to keep retiring
			if (exc_wait == 0)
			begin
				except   <= 1'b1;
				exc_wait = $urandom_range(6, 30);
			end
			else
			begin
				except   <= 1'b0;
				exc_wait--;
			end
			@(posedge clk);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== mini_core.f ====
+incdir+verif
src/mini_core_pkg.sv
src/fetch_unit.sv
src/inst_rom.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/mini_core.sv
verif/mini_core_tb.sv

// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - src/mini_core_pkg.sv
  - src/fetch_unit.sv
  - src/inst_rom.sv
  - src/reg_file.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/mini_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/mini_core_tb.sv
